/* Bender.yml */
package:
  name: wbuf

sources:
  - include_dirs:
      - common
    files:
      - common/wbuf_pkg.sv
      - write_buffer/wbuf_queue.sv
      - write_buffer/wbuf_drain.sv
      - src/wbuf_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_clkgen.sv
      - sim/tb_wbuf.sv

/* common/wbuf_defs.svh */
// write buffer sizing defines: queue depth, words per line, address width
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// number of buffered write-back entries
`define WBUF_DEPTH 5

// 32-bit words per cache line, also the burst length on the bus
`define WBUF_LINE_WORDS 8

// line address width
`define WBUF_ADDR_W 32

`endif

/* common/wbuf_pkg.sv */
// wbuf_pkg: line, entry, data beat and query response struct types
`include "wbuf_defs.svh"

package wbuf_pkg;

    // word 0 sits in the low bits
    typedef struct packed {
        logic [`WBUF_LINE_WORDS-1:0][31:0] word;
    } line_t;

    // one evicted dirty line waiting for write-back
    typedef struct packed {
        logic [`WBUF_ADDR_W-1:0] addr;
        line_t                   line;
    } wb_entry_t;

    // one beat on the write data channel
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } w_beat_t;

    // forwarded line for a cache read that hits the buffer
    typedef struct packed {
        logic  hit;
        line_t line;
    } query_rsp_t;

endpackage

/* sim/tb_clkgen.sv */
// testbench clock and reset generator
module tb_clkgen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

/* sim/tb_wbuf.sv */
// write buffer testbench with directed tests, bus slave model, reference queue and compare tasks
`include "wbuf_defs.svh"

module tb_wbuf;
    timeunit 1ns;
    timeprecision 1ps;

    import wbuf_pkg::*;

    localparam int WORDS = `WBUF_LINE_WORDS;
    localparam int DEPTH = `WBUF_DEPTH;
    // 40 entries of about 11 cycles each plus stalls on every channel and margin
    localparam int MAX_CYCLES = 4000;

    logic clk, rstn;
    logic in_valid, in_ready;
    wb_entry_t in_entry;
    logic [`WBUF_ADDR_W-1:0] query_addr, aw_addr;
    query_rsp_t query_rsp;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    w_beat_t w_beat;

    // slave model and monitor state
    wb_entry_t ref_q[$];
    wb_entry_t rebuilt;
    w_beat_t held_beat;
    logic beat_held = 1'b0;
    logic aw_seen = 1'b0;
    logic hold_aw, stall_en;
    int beat_idx = 0;
    int b_pending = 0;
    int aw_gap = 0;
    int w_gap = 0;
    int b_gap = 0;
    int done_cnt = 0;
    int cycles = 0;

    tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

    wbuf_top uut (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic mismatch(input string name, input string exp, input string act);
        fail_run($sformatf("CHECK FAILED at %0d ns: %s expected %s actual %s",
                           $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_entry(input string name, input wb_entry_t exp, input wb_entry_t act);
        if (act !== exp)
            mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_beat(input string name, input w_beat_t exp, input w_beat_t act);
        if (act !== exp)
            mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_query(input string name, input query_rsp_t exp, input query_rsp_t act);
        if (act !== exp)
            mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    function automatic int stall_cycles();
        return stall_en ? int'($urandom_range(3, 0)) : 0;
    endfunction

    function automatic wb_entry_t make_entry(input logic [31:0] addr, input logic [31:0] base);
        wb_entry_t e;
        e.addr = addr;
        for (int k = 0; k < WORDS; k++)
            e.line.word[k] = base + 32'(k);
        return e;
    endfunction

    function automatic query_rsp_t hit_rsp(input line_t line);
        query_rsp_t r;
        r.hit  = 1'b1;
        r.line = line;
        return r;
    endfunction

    // readies and the response are driven just after the rising edge
    initial begin : bus_slave
        forever begin
            @(posedge clk);
            #1;
            aw_ready = !hold_aw && (aw_gap == 0);
            w_ready  = (w_gap == 0);
            b_valid  = (b_pending > 0) && (b_gap == 0);
            aw_gap   = (aw_gap > 0) ? aw_gap - 1 : 0;
            w_gap    = (w_gap > 0) ? w_gap - 1 : 0;
            b_gap    = (b_gap > 0) ? b_gap - 1 : 0;
        end
    end

    // intake and write channel monitor on the falling edge
    always @(negedge clk) begin : monitor
        w_beat_t exp_beat;
        if (rstn) begin
            if (in_valid && in_ready)
                ref_q.push_back(in_entry);
            if (aw_valid && aw_ready) begin
                if (ref_q.size() == 0)
                    fail_run("address phase started with no entry buffered");
                if (aw_seen)
                    fail_run("second address phase started before the write response");
                rebuilt.addr = aw_addr;
                aw_seen = 1'b1;
                aw_gap = stall_cycles();
            end
            // a stalled beat must not change
            if (w_valid) begin
                if (beat_held)
                    check_beat("w_beat while stalled", held_beat, w_beat);
                held_beat = w_beat;
                beat_held = !w_ready;
            end else if (beat_held) begin
                fail_run("w_valid dropped before its beat completed");
            end
            if (w_valid && w_ready) begin
                if (!aw_seen || beat_idx >= WORDS)
                    fail_run("data beat seen outside a write burst");
                exp_beat.data = ref_q[0].line.word[beat_idx];
                exp_beat.last = (beat_idx == WORDS - 1);
                check_beat("w_beat", exp_beat, w_beat);
                rebuilt.line.word[beat_idx] = w_beat.data;
                beat_idx++;
                w_gap = stall_cycles();
                if (exp_beat.last) begin
                    b_pending++;
                    b_gap = stall_cycles();
                end
            end
            if (b_valid && b_ready) begin
                check_entry("write-back", ref_q[0], rebuilt);
                void'(ref_q.pop_front());
                done_cnt++;
                b_pending--;
                aw_seen = 1'b0;
                beat_idx = 0;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles >= MAX_CYCLES)
            fail_run("timeout: the tests did not finish within the cycle limit");
    end

    task automatic send_entry(input wb_entry_t e);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_entry = e;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic query_check(input logic [31:0] addr, input query_rsp_t exp);
        @(posedge clk);
        #1;
        query_addr = addr;
        @(negedge clk);
        check_query($sformatf("query_rsp for %h", addr), exp, query_rsp);
    endtask

    task automatic wait_drained();
        while (ref_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("aw_valid", 1'b0, aw_valid);
        check_bit("w_valid", 1'b0, w_valid);
        check_bit("b_ready", 1'b0, b_ready);
        check_bit("in_ready", 1'b1, in_ready);
        query_check(32'h0000_0000, '0);
        query_check(32'hdead_beef, '0);
    endtask

    task automatic test_single();
        wb_entry_t e;
        e = make_entry(32'h0000_1000, 32'h1111_0000);
        send_entry(e);
        wait_drained();
        query_check(e.addr, '0);
    endtask

    task automatic test_forward();
        wb_entry_t a, b, c;
        a = make_entry(32'h0000_2000, 32'haaaa_0000);
        b = make_entry(32'h0000_3000, 32'hbbbb_0000);
        c = make_entry(32'h0000_2000, 32'hcccc_0000);
        hold_aw = 1'b1;
        send_entry(a);
        send_entry(b);
        send_entry(c);
        // newer line for the same address wins
        query_check(a.addr, hit_rsp(c.line));
        query_check(b.addr, hit_rsp(b.line));
        query_check(32'h0000_4000, '0);
        hold_aw = 1'b0;
        wait_drained();
    endtask

    task automatic test_full();
        wb_entry_t extra;
        int done_before;
        hold_aw = 1'b1;
        for (int i = 0; i < DEPTH; i++)
            send_entry(make_entry(32'h0001_0000 + 32'(i) * 32'h40, 32'(i) << 8));
        extra = make_entry(32'h0002_0000, 32'h5555_0000);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_entry = extra;
        repeat (3) begin
            @(negedge clk);
            check_bit("in_ready", 1'b0, in_ready);
        end
        done_before = done_cnt;
        hold_aw = 1'b0;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        if (done_cnt == done_before)
            fail_run("held entry was accepted before any write-back completed");
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        wait_drained();
    endtask

    task automatic test_stream();
        stall_en = 1'b1;
        for (int i = 0; i < 30; i++) begin
            send_entry(make_entry($urandom, $urandom));
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
        wait_drained();
        stall_en = 1'b0;
    endtask

    initial begin : main
        int seed_ret;
        seed_ret = $urandom(85260);
        in_valid = 1'b0;
        in_entry = '0;
        query_addr = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        hold_aw = 1'b0;
        stall_en = 1'b0;
        @(posedge rstn);
        test_reset();
        test_single();
        test_forward();
        test_full();
        test_stream();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* src/wbuf_top.sv */
// wbuf_top: write buffer top level joining the queue and drain stages
`include "wbuf_defs.svh"

module wbuf_top (
    input  logic                    clk,
    input  logic                    rstn,

    // cache intake
    input  logic                    in_valid,
    input  wbuf_pkg::wb_entry_t     in_entry,
    output logic                    in_ready,

    // cache query
    input  logic [`WBUF_ADDR_W-1:0] query_addr,
    output wbuf_pkg::query_rsp_t    query_rsp,

    // memory bus write channels
    output logic                    aw_valid,
    output logic [`WBUF_ADDR_W-1:0] aw_addr,
    input  logic                    aw_ready,
    output logic                    w_valid,
    output wbuf_pkg::w_beat_t       w_beat,
    input  logic                    w_ready,
    input  logic                    b_valid,
    output logic                    b_ready
);

    import wbuf_pkg::*;

    logic      head_valid;
    wb_entry_t head;
    logic      head_pop;

    wbuf_queue u_queue (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_entry   (in_entry),
        .in_ready   (in_ready),
        .query_addr (query_addr),
        .query_rsp  (query_rsp),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop)
    );

    wbuf_drain u_drain (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w_beat     (w_beat),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

endmodule

/* wbuf.f */
+incdir+common
common/wbuf_pkg.sv
write_buffer/wbuf_queue.sv
write_buffer/wbuf_drain.sv
src/wbuf_top.sv
sim/tb_clkgen.sv
sim/tb_wbuf.sv

/* write_buffer/wbuf_drain.sv */
// wbuf_drain: FSM that writes the head entry to the bus as address, data burst and response
`include "wbuf_defs.svh"

module wbuf_drain (
    input  logic                    clk,
    input  logic                    rstn,

    // head of the queue
    input  logic                    head_valid,
    input  wbuf_pkg::wb_entry_t     head,
    output logic                    head_pop,

    // write address channel
    output logic                    aw_valid,
    output logic [`WBUF_ADDR_W-1:0] aw_addr,
    input  logic                    aw_ready,

    // write data channel
    output logic                    w_valid,
    output wbuf_pkg::w_beat_t       w_beat,
    input  logic                    w_ready,

    // write response channel
    input  logic                    b_valid,
    output logic                    b_ready
);

    import wbuf_pkg::*;

    localparam int LINE_WORDS = `WBUF_LINE_WORDS;
    localparam int BEAT_W     = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t            state;
    state_t            state_nxt;
    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_last;

    assign beat_last = (beat_cnt == BEAT_W'(LINE_WORDS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (head_valid) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                if (aw_ready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (w_ready && beat_last) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                // back to idle so bursts are separated by a cycle
                if (b_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (w_valid && w_ready) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // bus outputs decoded from state
    assign aw_valid = (state == ADDR);
    assign aw_addr  = head.addr;

    assign w_valid     = (state == DATA);
    assign w_beat.data = head.line.word[beat_cnt];
    assign w_beat.last = w_valid && beat_last;

    assign b_ready  = (state == RESP);
    // entry retires on the response handshake
    assign head_pop = b_ready && b_valid;

endmodule

/* write_buffer/wbuf_queue.sv */
// wbuf_queue: shift-register entry queue with intake, head output and address query
`include "wbuf_defs.svh"

module wbuf_queue (
    input  logic                    clk,
    input  logic                    rstn,

    // cache intake
    input  logic                    in_valid,
    input  wbuf_pkg::wb_entry_t     in_entry,
    output logic                    in_ready,

    // cache query
    input  logic [`WBUF_ADDR_W-1:0] query_addr,
    output wbuf_pkg::query_rsp_t    query_rsp,

    // oldest entry towards the drain stage
    output logic                    head_valid,
    output wbuf_pkg::wb_entry_t     head,
    input  logic                    head_pop
);

    import wbuf_pkg::*;

    localparam int DEPTH = `WBUF_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // newest entry at index 0, oldest at count-1
    wb_entry_t        slots [DEPTH];
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] head_idx;
    logic [DEPTH-1:0] match;

    logic push;
    logic pop;

    assign in_ready   = (count != CNT_W'(DEPTH));
    assign head_valid = (count != '0);

    assign push = in_valid && in_ready;
    assign pop  = head_pop && head_valid;

    // storage shifts up on every accepted insert
    always_ff @(posedge clk) begin
        if (push) begin
            slots[0] <= in_entry;
            for (int i = 1; i < DEPTH; i++) begin
                slots[i] <= slots[i-1];
            end
        end
    end

    // occupancy, a simultaneous push and pop leaves it unchanged
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head index follows count, so inserts never disturb the oldest entry
    assign head_idx = head_valid ? (count - 1'b1) : '0;
    assign head     = slots[head_idx];

    // only occupied slots take part in the compare
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match[i] = (i < int'(count)) && (slots[i].addr == query_addr);
        end
    end

    // newest match wins: walk from the oldest so index 0 is applied last
    always_comb begin
        query_rsp = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                query_rsp.hit  = 1'b1;
                query_rsp.line = slots[i].line;
            end
        end
    end

endmodule
